/* project.f */
routing_pkg.sv
pick_if.sv
lfsr_rng.sv
neighbor_table.sv
neighbor_index_picker.sv
policy_config.sv
winner_policy.sv
next_hop_selector.sv
tb_next_hop.sv

/* tb_next_hop.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_next_hop;

	localparam int max_decisions = 200;
	localparam int cycle_limit = max_decisions * 25 + 600; // decisions plus setup writes
	localparam logic [15:0] none_hop = 16'hffff;
	localparam logic [15:0] eps_full = 16'd16;
	localparam logic [4:0] count_slot = 5'd16;

	logic clock;
	logic nrst;
	logic start;
	logic [15:0] my_best;
	logic [15:0] best_hop;
	logic [15:0] best_value;
	logic [15:0] best_id;
	logic cfg_load;
	logic [15:0] cfg_epsilon;
	logic [15:0] cfg_step;
	logic [15:0] cfg_node_id;
	logic tbl_wr;
	logic [4:0] tbl_addr;
	logic [15:0] tbl_data;
	logic busy;
	logic done;
	logic [15:0] next_hop;
	logic [15:0] epsilon;

	// reference model state
	logic [15:0] tbl_copy [16];
	int tbl_count = 0;
	logic [15:0] last_hop = none_hop;
	logic [15:0] step_model = '0;
	logic [15:0] node_id_model = '0;

	int cycles = 0;
	int starts_taken = 0;
	int dones_seen = 0;
	bit pending = 1'b0;

	next_hop_selector dut (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	function automatic string value_error(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		return $sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
	endfunction

	// cycle limit, start and done bookkeeping
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit)
			abort_run("run timed out before all decisions finished");
		if (nrst) begin
			if (done) begin
				assert (pending) else abort_run("done appeared with no decision pending");
				dones_seen <= dones_seen + 1;
				pending <= 1'b0;
			end
			if (start && !busy) begin
				starts_taken <= starts_taken + 1;
				pending <= 1'b1;
			end
		end
	end

	done_single: assert property (@(posedge clock) disable iff (!nrst) done |=> !done)
		else abort_run("done stayed high for more than one cycle");

	busy_with_done: assert property (@(posedge clock) disable iff (!nrst)
		done |-> !busy && $past(busy))
		else abort_run("busy did not fall in the done cycle");

	busy_after_start: assert property (@(posedge clock) disable iff (!nrst)
		start && !busy |=> busy)
		else abort_run("busy did not rise after an accepted start");

	task automatic write_entry(input logic [4:0] addr, input logic [15:0] data);
		@(posedge clock);
		tbl_wr <= 1'b1;
		tbl_addr <= addr;
		tbl_data <= data;
		@(posedge clock);
		tbl_wr <= 1'b0;
	endtask

	task automatic fill_table(input int count);
		for (int i = 0; i < 16; i++) begin
			tbl_copy[i] = 16'($urandom);
			write_entry(5'(i), tbl_copy[i]);
		end
		write_entry(count_slot, 16'(count));
		tbl_count = count;
	endtask

	task automatic load_config(input logic [15:0] eps, input logic [15:0] step);
		@(posedge clock);
		cfg_load <= 1'b1;
		cfg_epsilon <= eps;
		cfg_step <= step;
		cfg_node_id <= node_id_model;
		@(posedge clock);
		cfg_load <= 1'b0;
		step_model = step;
		@(posedge clock); // loaded epsilon readable from here
	endtask

	// random route words, often a near tie with own best
	task automatic pick_route(output logic [15:0] mb, bh, bv, bid);
		bh = 16'($urandom);
		bid = ($urandom_range(0, 1) == 1) ? node_id_model : 16'($urandom);
		if ($urandom_range(0, 2) == 0) begin
			mb = 16'($urandom);
			bv = 16'($urandom);
		end else begin
			mb = 16'($urandom_range(20000, 60000));
			bv = mb - 16'd10 + 16'($urandom_range(0, 40));
		end
	endtask

	// two-step exploit rule on widened products
	function automatic logic [15:0] exploit_hop(input logic [15:0] mb, bh, bv, bid,
			output bit clear);
		longint unsigned near_l;
		longint unsigned near_r;
		longint unsigned far_l;
		longint unsigned far_r;
		near_l = 64'(bv) * 1024;
		near_r = 64'(mb) * 1023;
		far_l = 64'(bv) * 32768;
		far_r = 64'(mb) * 32801;
		clear = near_l < near_r;
		if (clear)
			return bh;
		if (far_l < far_r && bid != node_id_model)
			return bh;
		return last_hop;
	endfunction

	function automatic bit stored_neighbor(input logic [15:0] hop);
		for (int i = 0; i < tbl_count; i++)
			if (tbl_copy[i] == hop)
				return 1'b1;
		return 1'b0;
	endfunction

	// latency counts edges from start sampled to done sampled
	task automatic run_decision(input logic [15:0] mb, bh, bv, bid, input bit extra_start,
			output int latency);
		@(posedge clock);
		my_best <= mb;
		best_hop <= bh;
		best_value <= bv;
		best_id <= bid;
		start <= 1'b1;
		@(posedge clock);
		start <= extra_start; // seen while busy, must be ignored
		latency = 0;
		while (!done) begin
			@(posedge clock);
			start <= 1'b0;
			latency++;
		end
	endtask

	// mode 0 exploit only, 1 explore only, 2 either (told apart by epsilon)
	task automatic check_decision(input int mode);
		logic [15:0] mb, bh, bv, bid;
		logic [15:0] exp_hop;
		logic [15:0] prev_eps;
		logic [15:0] lowered;
		bit clear;
		bit explored;
		int latency;
		pick_route(mb, bh, bv, bid);
		exp_hop = exploit_hop(mb, bh, bv, bid, clear);
		prev_eps = epsilon;
		run_decision(mb, bh, bv, bid, $urandom_range(0, 3) == 0, latency);
		@(posedge clock); // epsilon moves one cycle after the decay pulse
		explored = (mode == 1) || (mode == 2 && epsilon != prev_eps);
		if (explored) begin
			assert (stored_neighbor(next_hop)) else abort_run($sformatf(
				"ERROR next_hop 0x%0h not among first %0d neighbors", next_hop, tbl_count));
			lowered = (prev_eps > step_model) ? prev_eps - step_model : '0;
			assert (epsilon == lowered) else abort_run(value_error("epsilon", epsilon, lowered));
			last_hop = next_hop;
		end else begin
			assert (next_hop == exp_hop)
				else abort_run(value_error("next_hop", next_hop, exp_hop));
			if (mode == 0)
				assert (latency == (clear ? 3 : 4))
					else abort_run(value_error("latency", latency, clear ? 3 : 4));
			assert (epsilon == prev_eps)
				else abort_run(value_error("epsilon", epsilon, prev_eps));
			last_hop = exp_hop;
		end
	endtask

	initial begin
		int n;
		void'($urandom(32'ha9cc));
		nrst = 1'b0;
		start = 1'b0;
		my_best = '0;
		best_hop = '0;
		best_value = '0;
		best_id = '0;
		cfg_load = 1'b0;
		cfg_epsilon = '0;
		cfg_step = '0;
		cfg_node_id = '0;
		tbl_wr = 1'b0;
		tbl_addr = '0;
		tbl_data = '0;
		repeat (2) @(posedge clock);
		nrst <= 1'b1;
		@(posedge clock);
		assert (next_hop == none_hop) else abort_run(value_error("next_hop", next_hop, none_hop));
		assert (!done && !busy) else abort_run("done or busy high after reset");
		assert (epsilon == '0) else abort_run(value_error("epsilon", epsilon, 0));
		repeat (5) @(posedge clock); // quiet period, monitor flags any done

		// exploit rule with exploration off
		node_id_model = 16'($urandom);
		load_config('0, '0);
		repeat (80) check_decision(0);

		// pure exploration over several table sizes
		load_config(eps_full, '0);
		for (int r = 0; r < 5; r++) begin
			fill_table($urandom_range(1, 16));
			repeat (10) check_decision(1);
		end

		// epsilon decay down to zero
		fill_table($urandom_range(4, 16));
		load_config(eps_full, 16'($urandom_range(3, 8)));
		check_decision(2);
		assert (epsilon == eps_full - step_model)
			else abort_run(value_error("epsilon", epsilon, eps_full - step_model));
		n = 0;
		while (epsilon != '0 && n < 40) begin
			check_decision(2);
			n++;
		end
		assert (epsilon == '0) else abort_run("epsilon did not decay to zero");

		// empty table falls back to the exploit rule
		write_entry(count_slot, '0);
		tbl_count = 0;
		load_config(eps_full, 16'd2);
		repeat (20) check_decision(0);

		repeat (3) @(posedge clock);
		assert (dones_seen == starts_taken)
			else abort_run(value_error("done count", dones_seen, starts_taken));
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* next_hop_selector.sv */
`timescale 1ns/1ps
`default_nettype none

module next_hop_selector (
	input wire clock,
	input wire nrst,
	input wire start,
	input wire [routing_pkg::word_width-1:0] my_best,
	input wire [routing_pkg::word_width-1:0] best_hop,
	input wire [routing_pkg::word_width-1:0] best_value,
	input wire [routing_pkg::word_width-1:0] best_id,
	input wire cfg_load,
	input wire [routing_pkg::word_width-1:0] cfg_epsilon,
	input wire [routing_pkg::word_width-1:0] cfg_step,
	input wire [routing_pkg::word_width-1:0] cfg_node_id,
	input wire tbl_wr,
	input wire [routing_pkg::addr_width-1:0] tbl_addr,
	input wire [routing_pkg::word_width-1:0] tbl_data,
	output logic busy,
	output logic done,
	output logic [routing_pkg::word_width-1:0] next_hop,
	output logic [routing_pkg::word_width-1:0] epsilon
);

	logic [routing_pkg::word_width-1:0] rnd;
	logic [routing_pkg::addr_width-1:0] rd_addr;
	logic [routing_pkg::word_width-1:0] rd_data;
	logic [routing_pkg::word_width-1:0] node_id;
	logic decay;

	pick_if pick_bus ();

	lfsr_rng u_rng (
		.clock(clock),
		.nrst(nrst),
		.rnd(rnd)
	);

	neighbor_table u_table (
		.clock(clock),
		.nrst(nrst),
		.wr(tbl_wr),
		.wr_addr(tbl_addr),
		.wr_data(tbl_data),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	neighbor_index_picker u_picker (
		.clock(clock),
		.nrst(nrst),
		.rnd(rnd),
		.pk(pick_bus.picker)
	);

	policy_config u_config (
		.clock(clock),
		.nrst(nrst),
		.load(cfg_load),
		.epsilon_in(cfg_epsilon),
		.step_in(cfg_step),
		.node_id_in(cfg_node_id),
		.decay(decay),
		.epsilon(epsilon),
		.node_id(node_id)
	);

	winner_policy u_policy (
		.clock(clock),
		.nrst(nrst),
		.start(start),
		.rnd(rnd),
		.my_best(my_best),
		.best_hop(best_hop),
		.best_value(best_value),
		.best_id(best_id),
		.epsilon(epsilon),
		.node_id(node_id),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.pk(pick_bus.policy),
		.decay(decay),
		.busy(busy),
		.done(done),
		.next_hop(next_hop)
	);

endmodule

`default_nettype wire

/* winner_policy.sv */
`timescale 1ns/1ps
`default_nettype none

module winner_policy (
	input wire clock,
	input wire nrst,
	input wire start,
	input wire [routing_pkg::word_width-1:0] rnd,
	input wire [routing_pkg::word_width-1:0] my_best,
	input wire [routing_pkg::word_width-1:0] best_hop,
	input wire [routing_pkg::word_width-1:0] best_value,
	input wire [routing_pkg::word_width-1:0] best_id,
	input wire [routing_pkg::word_width-1:0] epsilon,
	input wire [routing_pkg::word_width-1:0] node_id,
	output logic [routing_pkg::addr_width-1:0] rd_addr,
	input wire [routing_pkg::word_width-1:0] rd_data,
	pick_if.policy pk,
	output logic decay,
	output logic busy,
	output logic done,
	output logic [routing_pkg::word_width-1:0] next_hop
);

	logic [2:0] state;
	logic [routing_pkg::rnd_bits-1:0] draw; // explore draw
	logic explore;
	logic near_win;
	logic far_win;

	// widened products of 12.4 values and the scale constants
	logic [2*routing_pkg::word_width-1:0] near_lhs;
	logic [2*routing_pkg::word_width-1:0] near_rhs;
	logic [2*routing_pkg::word_width-1:0] far_lhs;
	logic [2*routing_pkg::word_width-1:0] far_rhs;

	assign near_lhs = best_value * routing_pkg::near_scale;
	assign near_rhs = my_best * routing_pkg::near_factor;
	assign far_lhs = best_value * routing_pkg::far_scale;
	assign far_rhs = my_best * routing_pkg::far_factor;

	assign near_win = near_lhs < near_rhs; // clearly better than own best
	assign far_win = far_lhs < far_rhs; // within ~0.1 percent
	assign explore = draw < epsilon && rd_data != '0; // rd_data holds the count here

	assign busy = state != routing_pkg::st_idle;

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state <= routing_pkg::st_idle;
			done <= 1'b0;
			decay <= 1'b0;
			pk.start <= 1'b0;
			next_hop <= routing_pkg::no_hop;
		end else begin
			done <= 1'b0;
			decay <= 1'b0;
			pk.start <= 1'b0;
			case (state)
				routing_pkg::st_idle: begin
					if (start)
						state <= routing_pkg::st_count;
				end
				routing_pkg::st_count: state <= routing_pkg::st_decide; // count read in flight
				routing_pkg::st_decide: begin
					if (explore) begin
						pk.start <= 1'b1;
						state <= routing_pkg::st_pick;
					end else if (near_win) begin
						next_hop <= best_hop;
						done <= 1'b1;
						state <= routing_pkg::st_idle;
					end else begin
						state <= routing_pkg::st_narrow;
					end
				end
				routing_pkg::st_narrow: begin
					// a narrow win only counts when the hop is not this node
					if (far_win && best_id != node_id)
						next_hop <= best_hop;
					done <= 1'b1;
					state <= routing_pkg::st_idle;
				end
				routing_pkg::st_pick: begin
					if (pk.done)
						state <= routing_pkg::st_fetch;
				end
				routing_pkg::st_fetch: state <= routing_pkg::st_load; // entry read in flight
				routing_pkg::st_load: begin
					next_hop <= rd_data;
					done <= 1'b1;
					decay <= 1'b1; // each exploration lowers epsilon
					state <= routing_pkg::st_idle;
				end
				default: state <= routing_pkg::st_idle;
			endcase
		end
	end

	// table address, draw and pick count
	always_ff @(posedge clock) begin
		case (state)
			routing_pkg::st_idle: rd_addr <= routing_pkg::count_addr;
			routing_pkg::st_count: draw <= rnd[routing_pkg::rnd_bits-1:0];
			routing_pkg::st_decide: pk.count <= rd_data[routing_pkg::addr_width-1:0];
			routing_pkg::st_pick: begin
				if (pk.done)
					rd_addr <= pk.index;
			end
			default: ;
		endcase
	end

	a_done_pulse: assert property (@(posedge clock) disable iff (!nrst)
		done |=> !done);

	a_decay_with_done: assert property (@(posedge clock) disable iff (!nrst)
		decay |-> done);

endmodule

`default_nettype wire

/* policy_config.sv */
`timescale 1ns/1ps
`default_nettype none

module policy_config (
	input wire clock,
	input wire nrst,
	input wire load,
	input wire [routing_pkg::word_width-1:0] epsilon_in,
	input wire [routing_pkg::word_width-1:0] step_in,
	input wire [routing_pkg::word_width-1:0] node_id_in,
	input wire decay,
	output logic [routing_pkg::word_width-1:0] epsilon,
	output logic [routing_pkg::word_width-1:0] node_id
);

	logic [routing_pkg::word_width-1:0] step;

	// load has priority over decay
	always_ff @(posedge clock) begin
		if (!nrst) begin
			epsilon <= '0;
			step <= '0;
			node_id <= '0;
		end else if (load) begin
			if (epsilon_in > routing_pkg::epsilon_max)
				epsilon <= routing_pkg::epsilon_max;
			else
				epsilon <= epsilon_in;
			step <= step_in;
			node_id <= node_id_in;
		end else if (decay) begin
			epsilon <= (epsilon > step) ? epsilon - step : '0; // floor at zero
		end
	end

	a_eps_no_rise: assert property (@(posedge clock) disable iff (!nrst)
		!load |=> epsilon <= $past(epsilon));

endmodule

`default_nettype wire

/* neighbor_index_picker.sv */
`timescale 1ns/1ps
`default_nettype none

module neighbor_index_picker (
	input wire clock,
	input wire nrst,
	input wire [routing_pkg::word_width-1:0] rnd,
	pick_if.picker pk
);

	logic running;
	logic [routing_pkg::pick_bits-1:0] rem; // running remainder
	logic [routing_pkg::addr_width-1:0] cnt; // latched divisor
	logic [routing_pkg::pick_bits+routing_pkg::addr_width-2:0] div; // shifted count

	always_ff @(posedge clock) begin
		if (!nrst) begin
			running <= 1'b0;
			pk.done <= 1'b0;
		end else begin
			pk.done <= 1'b0;
			if (pk.start) begin
				running <= 1'b1;
			end else if (running && rem < cnt) begin
				running <= 1'b0;
				pk.done <= 1'b1;
			end
		end
	end

	// subtract shifted copies of count, largest first
	// at most pick_bits subtract steps, so done within 2..10 cycles
	always_ff @(posedge clock) begin
		if (pk.start) begin
			rem <= rnd[routing_pkg::pick_bits-1:0];
			cnt <= pk.count;
			div <= {pk.count, {(routing_pkg::pick_bits-1){1'b0}}};
		end else if (running && rem >= cnt) begin
			if (rem >= div)
				rem <= rem - div[routing_pkg::pick_bits-1:0];
			div <= div >> 1;
		end
		if (running && rem < cnt)
			pk.index <= rem[routing_pkg::addr_width-1:0]; // remainder fits, below count
	end

	// policy must keep count stable, so the answer is in range on its side too
	a_index_range: assert property (@(posedge clock) disable iff (!nrst)
		pk.done |-> pk.index < pk.count);

endmodule

`default_nettype wire

/* neighbor_table.sv */
`timescale 1ns/1ps
`default_nettype none

module neighbor_table (
	input wire clock,
	input wire nrst,
	input wire wr,
	input wire [routing_pkg::addr_width-1:0] wr_addr,
	input wire [routing_pkg::word_width-1:0] wr_data,
	input wire [routing_pkg::addr_width-1:0] rd_addr,
	output logic [routing_pkg::word_width-1:0] rd_data
);

	logic [routing_pkg::word_width-1:0] hops [routing_pkg::table_entries];
	logic [routing_pkg::addr_width-1:0] count; // number of valid neighbors

	// count register, clipped to the table size
	always_ff @(posedge clock) begin
		if (!nrst) begin
			count <= '0;
		end else if (wr && wr_addr == routing_pkg::count_addr) begin
			if (wr_data > routing_pkg::table_entries)
				count <= routing_pkg::addr_width'(routing_pkg::table_entries);
			else
				count <= wr_data[routing_pkg::addr_width-1:0];
		end
	end

	// hop entries, addresses above count_addr are dropped
	always_ff @(posedge clock) begin
		if (wr && wr_addr < routing_pkg::count_addr)
			hops[wr_addr[routing_pkg::index_width-1:0]] <= wr_data;
	end

	// registered read, one cycle behind rd_addr
	always_ff @(posedge clock) begin
		if (rd_addr == routing_pkg::count_addr)
			rd_data <= {{(routing_pkg::word_width - routing_pkg::addr_width){1'b0}}, count};
		else
			rd_data <= hops[rd_addr[routing_pkg::index_width-1:0]];
	end

	a_count_range: assert property (@(posedge clock) disable iff (!nrst)
		count <= routing_pkg::table_entries);

endmodule

`default_nettype wire

/* lfsr_rng.sv */
`timescale 1ns/1ps
`default_nettype none

module lfsr_rng (
	input wire clock,
	input wire nrst,
	output logic [routing_pkg::word_width-1:0] rnd
);

	// galois form, shift right and fold taps on the dropped bit
	always_ff @(posedge clock) begin
		if (!nrst) begin
			rnd <= routing_pkg::rng_seed;
		end else begin
			rnd <= {1'b0, rnd[routing_pkg::word_width-1:1]}
				^ (rnd[0] ? routing_pkg::lfsr_taps : '0);
		end
	end

	// an all-zero state would lock up the sequence
	a_never_zero: assert property (@(posedge clock) disable iff (!nrst)
		rnd != '0);

endmodule

`default_nettype wire

/* pick_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface pick_if;

	logic start; // one-cycle request, picker idle
	logic [routing_pkg::addr_width-1:0] count; // held while picker works
	logic done;
	logic [routing_pkg::addr_width-1:0] index; // valid from done until next start

	modport policy (
		output start,
		output count,
		input done,
		input index
	);

	modport picker (
		input start,
		input count,
		output done,
		output index
	);

endinterface

`default_nettype wire

/* routing_pkg.sv */
`default_nettype none

package routing_pkg;

	// route words, hop ids and values
	localparam int word_width = 16;

	// neighbor table geometry
	localparam int table_entries = 16;
	localparam int index_width = $clog2(table_entries);
	localparam int addr_width = 5;
	localparam logic [addr_width-1:0] count_addr = 5'd16; // slot past the entries

	localparam logic [word_width-1:0] no_hop = '1;

	// explore draw and picker draw widths
	localparam int rnd_bits = 4;
	localparam int pick_bits = 8;
	localparam logic [word_width-1:0] epsilon_max = 16'd16; // always explores

	// ~0.999 with 10 fraction bits, ~1.001 with 15 fraction bits
	localparam int unsigned near_scale = 1024;
	localparam int unsigned near_factor = 1023;
	localparam int unsigned far_scale = 32768;
	localparam int unsigned far_factor = 32801;

	localparam logic [word_width-1:0] rng_seed = 16'hace1;
	localparam logic [word_width-1:0] lfsr_taps = 16'hb400; // x^16+x^14+x^13+x^11+1

	// winner_policy states
	localparam logic [2:0] st_idle = 3'd0;
	localparam logic [2:0] st_count = 3'd1;
	localparam logic [2:0] st_decide = 3'd2;
	localparam logic [2:0] st_narrow = 3'd3;
	localparam logic [2:0] st_pick = 3'd4;
	localparam logic [2:0] st_fetch = 3'd5;
	localparam logic [2:0] st_load = 3'd6;

endpackage

`default_nettype wire
